// ==== src/mipsControlPkg.sv ====
package mipsControlPkg;

    // Field widths fixed by the MIPS instruction format
    localparam int instrWidth   = 32;
    localparam int opcodeWidth  = 6;
    localparam int functWidth   = 6;
    localparam int regAddrWidth = 5;

    // Primary opcodes, instr[31:26]
    localparam logic [opcodeWidth-1:0] opRtype  = 6'd0;
    localparam logic [opcodeWidth-1:0] opRegimm = 6'd1;   // bltz and bgez, picked by rt
    localparam logic [opcodeWidth-1:0] opJ      = 6'd2;
    localparam logic [opcodeWidth-1:0] opJal    = 6'd3;
    localparam logic [opcodeWidth-1:0] opBeq    = 6'd4;
    localparam logic [opcodeWidth-1:0] opBne    = 6'd5;
    localparam logic [opcodeWidth-1:0] opBlez   = 6'd6;
    localparam logic [opcodeWidth-1:0] opBgtz   = 6'd7;
    localparam logic [opcodeWidth-1:0] opAddi   = 6'd8;
    localparam logic [opcodeWidth-1:0] opAddiu  = 6'd9;
    localparam logic [opcodeWidth-1:0] opSlti   = 6'd10;
    localparam logic [opcodeWidth-1:0] opSltiu  = 6'd11;
    localparam logic [opcodeWidth-1:0] opAndi   = 6'd12;
    localparam logic [opcodeWidth-1:0] opOri    = 6'd13;
    localparam logic [opcodeWidth-1:0] opXori   = 6'd14;
    localparam logic [opcodeWidth-1:0] opLui    = 6'd15;
    localparam logic [opcodeWidth-1:0] opLb     = 6'd32;
    localparam logic [opcodeWidth-1:0] opLh     = 6'd33;
    localparam logic [opcodeWidth-1:0] opLw     = 6'd35;
    localparam logic [opcodeWidth-1:0] opLbu    = 6'd36;
    localparam logic [opcodeWidth-1:0] opLhu    = 6'd37;
    localparam logic [opcodeWidth-1:0] opSb     = 6'd40;
    localparam logic [opcodeWidth-1:0] opSh     = 6'd41;
    localparam logic [opcodeWidth-1:0] opSw     = 6'd43;

    // R-type funct codes, instr[5:0]
    localparam logic [functWidth-1:0] functSll  = 6'd0;
    localparam logic [functWidth-1:0] functSrl  = 6'd2;
    localparam logic [functWidth-1:0] functSra  = 6'd3;
    localparam logic [functWidth-1:0] functSllv = 6'd4;
    localparam logic [functWidth-1:0] functSrlv = 6'd6;
    localparam logic [functWidth-1:0] functSrav = 6'd7;
    localparam logic [functWidth-1:0] functJr   = 6'd8;
    localparam logic [functWidth-1:0] functJalr = 6'd9;
    localparam logic [functWidth-1:0] functAdd  = 6'd32;
    localparam logic [functWidth-1:0] functAddu = 6'd33;
    localparam logic [functWidth-1:0] functSub  = 6'd34;
    localparam logic [functWidth-1:0] functSubu = 6'd35;
    localparam logic [functWidth-1:0] functAnd  = 6'd36;
    localparam logic [functWidth-1:0] functOr   = 6'd37;
    localparam logic [functWidth-1:0] functXor  = 6'd38;
    localparam logic [functWidth-1:0] functNor  = 6'd39;
    localparam logic [functWidth-1:0] functSlt  = 6'd42;
    localparam logic [functWidth-1:0] functSltu = 6'd43;

    // rt selects under opRegimm
    localparam logic [regAddrWidth-1:0] rtBltz = 5'd0;
    localparam logic [regAddrWidth-1:0] rtBgez = 5'd1;

    typedef enum logic [4:0] {
        aluNop, aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra,
        aluAndi, aluOri, aluXori, aluLui,
        aluBne, aluBlez, aluBgtz, aluBltz, aluBgez
    } aluOp_t;

    typedef enum logic [1:0] {regDstRt, regDstRd, regDstRa} regDst_t;       // Ra is r31

    typedef enum logic [1:0] {memToRegAlu, memToRegMem, memToRegPc4} memToReg_t;

    typedef enum logic [1:0] {npcSeq, npcBranch, npcJump} npcType_t;

    typedef enum logic [2:0] {
        memRNone, memRWord, memRByte, memRByteU, memRHalf, memRHalfU
    } memRBits_t;

    typedef enum logic [1:0] {memWrNone, memWrWord, memWrHalf, memWrByte} memWrBits_t;

    // Code 1 means shamt on operand A and the immediate on operand B
    typedef logic [1:0] aluSrc_t;
    localparam aluSrc_t aluSrcReg   = 2'd0;
    localparam aluSrc_t aluSrcShamt = 2'd1;
    localparam aluSrc_t aluSrcImm   = 2'd1;

    typedef struct packed {
        logic       illegal;
        logic       regWrite;
        regDst_t    regDst;
        memToReg_t  memToReg;
        logic       memRead;
        logic       memWrite;
        memRBits_t  memRBits;
        memWrBits_t memWrBits;
        aluOp_t     aluOp;
        aluSrc_t    aluSrcA;
        aluSrc_t    aluSrcB;
        npcType_t   npcType;
        logic       pcSrc;
        logic       jumpSrc;      // Jump target from rs
    } ctrlWord_t;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic                  adr;
        logic [instrWidth-1:0] dat;
    } wbReq_t;

    typedef struct packed {
        logic                  ack;
        logic [instrWidth-1:0] dat;
    } wbRsp_t;

endpackage

// ==== src/functDecoder.sv ====
`timescale 1ns/1ps

module functDecoder
(
    input  logic [mipsControlPkg::instrWidth-1:0] instr,
    output mipsControlPkg::ctrlWord_t             ctrl
);

    logic [mipsControlPkg::functWidth-1:0] funct;

    assign funct = instr[mipsControlPkg::functWidth-1:0];

    // Opcode is not checked here, the combiner owns that choice
    always_comb
    begin
        ctrl          = '0;
        ctrl.regWrite = 1'b1;                         // Common case, ALU result to rd
        ctrl.regDst   = mipsControlPkg::regDstRd;
        case (funct)
            mipsControlPkg::functSll:
            begin
                ctrl.aluOp   = mipsControlPkg::aluSll;
                ctrl.aluSrcA = mipsControlPkg::aluSrcShamt;
            end
            mipsControlPkg::functSrl:
            begin
                ctrl.aluOp   = mipsControlPkg::aluSrl;
                ctrl.aluSrcA = mipsControlPkg::aluSrcShamt;
            end
            mipsControlPkg::functSra:
            begin
                ctrl.aluOp   = mipsControlPkg::aluSra;
                ctrl.aluSrcA = mipsControlPkg::aluSrcShamt;
            end
            mipsControlPkg::functSllv:
                ctrl.aluOp = mipsControlPkg::aluSll;  // Amount from rs
            mipsControlPkg::functSrlv:
                ctrl.aluOp = mipsControlPkg::aluSrl;
            mipsControlPkg::functSrav:
                ctrl.aluOp = mipsControlPkg::aluSra;
            mipsControlPkg::functAdd, mipsControlPkg::functAddu:
                ctrl.aluOp = mipsControlPkg::aluAdd;
            mipsControlPkg::functSub, mipsControlPkg::functSubu:
                ctrl.aluOp = mipsControlPkg::aluSub;
            mipsControlPkg::functAnd:
                ctrl.aluOp = mipsControlPkg::aluAnd;
            mipsControlPkg::functOr:
                ctrl.aluOp = mipsControlPkg::aluOr;
            mipsControlPkg::functXor:
                ctrl.aluOp = mipsControlPkg::aluXor;
            mipsControlPkg::functNor:
                ctrl.aluOp = mipsControlPkg::aluNor;
            mipsControlPkg::functSlt:
                ctrl.aluOp = mipsControlPkg::aluSlt;
            mipsControlPkg::functSltu:
                ctrl.aluOp = mipsControlPkg::aluSltu;
            mipsControlPkg::functJr:
            begin
                ctrl.regWrite = 1'b0;                 // Pure jump, nothing written back
                ctrl.regDst   = mipsControlPkg::regDstRt;
                ctrl.npcType  = mipsControlPkg::npcJump;
                ctrl.jumpSrc  = 1'b1;
            end
            mipsControlPkg::functJalr:
            begin
                ctrl.memToReg = mipsControlPkg::memToRegPc4;   // Link into rd
                ctrl.npcType  = mipsControlPkg::npcJump;
                ctrl.jumpSrc  = 1'b1;
            end
            default:
            begin
                ctrl         = '0;
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== src/opcodeDecoder.sv ====
`timescale 1ns/1ps

module opcodeDecoder
(
    input  logic [mipsControlPkg::instrWidth-1:0] instr,
    output mipsControlPkg::ctrlWord_t             ctrl
);

    localparam int rtLsb = 16;

    logic [mipsControlPkg::opcodeWidth-1:0]  opcode;
    logic [mipsControlPkg::regAddrWidth-1:0] rt;

    assign opcode = instr[mipsControlPkg::instrWidth-1 -: mipsControlPkg::opcodeWidth];
    assign rt     = instr[rtLsb +: mipsControlPkg::regAddrWidth];

    // rs op imm into rt
    function automatic mipsControlPkg::ctrlWord_t immCtrl(
        input mipsControlPkg::aluOp_t op
    );
        mipsControlPkg::ctrlWord_t c;
        c          = '0;
        c.regWrite = 1'b1;
        c.regDst   = mipsControlPkg::regDstRt;
        c.aluSrcB  = mipsControlPkg::aluSrcImm;
        c.aluOp    = op;
        return c;
    endfunction

    function automatic mipsControlPkg::ctrlWord_t loadCtrl(
        input mipsControlPkg::memRBits_t rBits
    );
        mipsControlPkg::ctrlWord_t c;
        c          = immCtrl(mipsControlPkg::aluAdd);   // Address is rs + imm
        c.memToReg = mipsControlPkg::memToRegMem;
        c.memRead  = 1'b1;
        c.memRBits = rBits;
        return c;
    endfunction

    function automatic mipsControlPkg::ctrlWord_t storeCtrl(
        input mipsControlPkg::memWrBits_t wrBits
    );
        mipsControlPkg::ctrlWord_t c;
        c           = '0;
        c.memWrite  = 1'b1;
        c.memWrBits = wrBits;
        c.aluOp     = mipsControlPkg::aluAdd;
        c.aluSrcB   = mipsControlPkg::aluSrcImm;
        return c;
    endfunction

    // Compare happens in the ALU, target from the branch unit
    function automatic mipsControlPkg::ctrlWord_t branchCtrl(
        input mipsControlPkg::aluOp_t op
    );
        mipsControlPkg::ctrlWord_t c;
        c         = '0;
        c.pcSrc   = 1'b1;
        c.npcType = mipsControlPkg::npcBranch;
        c.aluOp   = op;
        return c;
    endfunction

    always_comb
    begin
        ctrl         = '0;
        ctrl.illegal = 1'b1;                          // Cleared by every known opcode
        case (opcode)
            mipsControlPkg::opAddi, mipsControlPkg::opAddiu:
                ctrl = immCtrl(mipsControlPkg::aluAdd);
            mipsControlPkg::opSlti:
                ctrl = immCtrl(mipsControlPkg::aluSlt);
            mipsControlPkg::opSltiu:
                ctrl = immCtrl(mipsControlPkg::aluSltu);
            mipsControlPkg::opAndi:
                ctrl = immCtrl(mipsControlPkg::aluAndi);
            mipsControlPkg::opOri:
                ctrl = immCtrl(mipsControlPkg::aluOri);
            mipsControlPkg::opXori:
                ctrl = immCtrl(mipsControlPkg::aluXori);
            mipsControlPkg::opLui:
                ctrl = immCtrl(mipsControlPkg::aluLui);
            mipsControlPkg::opLw:
                ctrl = loadCtrl(mipsControlPkg::memRWord);
            mipsControlPkg::opLb:
                ctrl = loadCtrl(mipsControlPkg::memRByte);
            mipsControlPkg::opLbu:
                ctrl = loadCtrl(mipsControlPkg::memRByteU);
            mipsControlPkg::opLh:
                ctrl = loadCtrl(mipsControlPkg::memRHalf);
            mipsControlPkg::opLhu:
                ctrl = loadCtrl(mipsControlPkg::memRHalfU);
            mipsControlPkg::opSw:
                ctrl = storeCtrl(mipsControlPkg::memWrWord);
            mipsControlPkg::opSh:
                ctrl = storeCtrl(mipsControlPkg::memWrHalf);
            mipsControlPkg::opSb:
                ctrl = storeCtrl(mipsControlPkg::memWrByte);
            mipsControlPkg::opBeq:
                ctrl = branchCtrl(mipsControlPkg::aluSub);     // Equal when difference is zero
            mipsControlPkg::opBne:
                ctrl = branchCtrl(mipsControlPkg::aluBne);
            mipsControlPkg::opBlez:
                ctrl = branchCtrl(mipsControlPkg::aluBlez);
            mipsControlPkg::opBgtz:
                ctrl = branchCtrl(mipsControlPkg::aluBgtz);
            mipsControlPkg::opRegimm:
            begin
                if (rt == mipsControlPkg::rtBltz)
                    ctrl = branchCtrl(mipsControlPkg::aluBltz);
                else if (rt == mipsControlPkg::rtBgez)
                    ctrl = branchCtrl(mipsControlPkg::aluBgez);
            end
            mipsControlPkg::opJ:
            begin
                ctrl.illegal = 1'b0;
                ctrl.npcType = mipsControlPkg::npcJump;   // Target from instr_index
            end
            mipsControlPkg::opJal:
            begin
                ctrl.illegal  = 1'b0;
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = mipsControlPkg::regDstRa;
                ctrl.memToReg = mipsControlPkg::memToRegPc4;
                ctrl.npcType  = mipsControlPkg::npcJump;
            end
            default:
                ctrl.illegal = 1'b1;                  // Includes opRtype
        endcase
    end

endmodule

// ==== src/controlCombine.sv ====
`timescale 1ns/1ps

module controlCombine
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [mipsControlPkg::instrWidth-1:0] instr,
    input  mipsControlPkg::ctrlWord_t             rtypeCtrl,
    input  mipsControlPkg::ctrlWord_t             otherCtrl,
    output mipsControlPkg::ctrlWord_t             ctrl
);

    logic                      isRtype;
    mipsControlPkg::ctrlWord_t nextCtrl;

    assign isRtype = instr[mipsControlPkg::instrWidth-1 -: mipsControlPkg::opcodeWidth]
                     == mipsControlPkg::opRtype;

    assign nextCtrl = isRtype ? rtypeCtrl : otherCtrl;

    // Loads every cycle, so the word trails the instruction register by one clock
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl <= '0;
        end
        else
        begin
            ctrl <= nextCtrl;
        end
    end

endmodule

// ==== src/controlBusPort.sv ====
`timescale 1ns/1ps

module controlBusPort
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  mipsControlPkg::wbReq_t                wbReq,
    output mipsControlPkg::wbRsp_t                wbRsp,
    input  mipsControlPkg::ctrlWord_t             ctrl,
    output logic [mipsControlPkg::instrWidth-1:0] instr
);

    localparam int padWidth = mipsControlPkg::instrWidth - $bits(mipsControlPkg::ctrlWord_t);

    logic                                  ack;
    logic                                  req;
    logic                                  accept;
    logic [mipsControlPkg::instrWidth-1:0] instrReg;

    assign req    = wbReq.cyc && wbReq.stb;
    assign accept = req && !ack;                      // No second ack for a held request

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ack      <= 1'b0;
            instrReg <= '0;
        end
        else
        begin
            ack <= accept;
            if (accept && wbReq.we && (wbReq.adr == 1'b0))
            begin
                instrReg <= wbReq.dat;                // Address 1 writes are dropped
            end
        end
    end

    assign instr     = instrReg;
    assign wbRsp.ack = ack;

    // Master holds adr through the ack cycle
    always_comb
    begin
        if (wbReq.adr)
        begin
            wbRsp.dat = {{padWidth{1'b0}}, ctrl};
        end
        else
        begin
            wbRsp.dat = instrReg;
        end
    end

endmodule

// ==== src/mipsControl.sv ====
`timescale 1ns/1ps

module mipsControl
(
    input  logic                   clk,
    input  logic                   reset,
    input  mipsControlPkg::wbReq_t wbReq,
    output mipsControlPkg::wbRsp_t wbRsp
);

    logic [mipsControlPkg::instrWidth-1:0] instr;
    mipsControlPkg::ctrlWord_t             rtypeCtrl;
    mipsControlPkg::ctrlWord_t             otherCtrl;
    mipsControlPkg::ctrlWord_t             ctrl;

    // Host side, instruction register and readback
    controlBusPort busPort_i
    (
        .clk   (clk),
        .reset (reset),
        .wbReq (wbReq),
        .wbRsp (wbRsp),
        .ctrl  (ctrl),
        .instr (instr)
    );

    functDecoder functDec_i
    (
        .instr (instr),
        .ctrl  (rtypeCtrl)
    );

    opcodeDecoder opcodeDec_i
    (
        .instr (instr),
        .ctrl  (otherCtrl)
    );

    // Picks by opcode and registers
    controlCombine combine_i
    (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .rtypeCtrl (rtypeCtrl),
        .otherCtrl (otherCtrl),
        .ctrl      (ctrl)
    );

endmodule

// ==== bench/mipsControlAssert.sv ====
`timescale 1ns/1ps

module mipsControlAssert
(
    input logic                                  clk,
    input logic                                  reset,
    input logic [mipsControlPkg::instrWidth-1:0] instr,
    input mipsControlPkg::ctrlWord_t             ctrl,
    input logic                                  req,
    input logic                                  ack
);

    int failCount = 0;

    logic [mipsControlPkg::opcodeWidth-1:0] opcode;
    logic                                   isLoad;
    logic                                   isStore;
    logic                                   isBranch;

    assign opcode   = instr[31:26];
    assign isLoad   = opcode inside {mipsControlPkg::opLb, mipsControlPkg::opLh,
                                     mipsControlPkg::opLw, mipsControlPkg::opLbu,
                                     mipsControlPkg::opLhu};
    assign isStore  = opcode inside {mipsControlPkg::opSb, mipsControlPkg::opSh,
                                     mipsControlPkg::opSw};
    assign isBranch = (opcode inside {mipsControlPkg::opBeq, mipsControlPkg::opBne,
                                      mipsControlPkg::opBlez, mipsControlPkg::opBgtz})
                      || (opcode == mipsControlPkg::opRegimm && instr[20:16] < 5'd2);

    // Control word trails the instruction by one clock
    assert property (@(posedge clk) disable iff (reset)
        isLoad |=> ctrl.memRead && (ctrl.memRBits != mipsControlPkg::memRNone))
    else
    begin
        $error("Load decoded without memRead or read type");
        failCount++;
    end

    assert property (@(posedge clk) disable iff (reset)
        isStore |=> ctrl.memWrite && !ctrl.regWrite)
    else
    begin
        $error("Store decoded without memWrite or with regWrite");
        failCount++;
    end

    assert property (@(posedge clk) disable iff (reset) isBranch |=> ctrl.pcSrc)
    else
    begin
        $error("Branch decoded without pcSrc");
        failCount++;
    end

    assert property (@(posedge clk) disable iff (reset)
        ctrl.illegal |-> (ctrl[$bits(ctrl)-2:0] == '0))
    else
    begin
        $error("Illegal word carries nonzero fields");
        failCount++;
    end

    // Single-cycle ack, only after a request
    assert property (@(posedge clk) disable iff (reset) ack |-> $past(req) ##1 !ack)
    else
    begin
        $error("Bus ack without request or longer than one cycle");
        failCount++;
    end

endmodule

bind controlCombine mipsControlAssert combineChk_i
(
    .clk   (clk),
    .reset (reset),
    .instr (instr),
    .ctrl  (ctrl),
    .req   (1'b0),
    .ack   (1'b0)
);

bind controlBusPort mipsControlAssert busChk_i
(
    .clk   (clk),
    .reset (reset),
    .instr (instr),
    .ctrl  (ctrl),
    .req   (req),
    .ack   (ack)
);

// ==== bench/mipsControlTb.sv ====
`timescale 1ns/1ps

module mipsControlTb;

    localparam int clkPeriod     = 40;
    localparam int resetCycles   = 10;
    localparam int functCount    = 18;
    localparam int opcodeCount   = 22;
    localparam int directedCount = functCount + opcodeCount + 6;   // Plus regimm, illegal and adr 1
    localparam int randomCount   = 200;
    localparam int timeoutCycles = (directedCount + randomCount) * 8 + resetCycles;

    // Supported funct codes of 6 bits each
    localparam logic [functCount*6-1:0] functList = {
        6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd8, 6'd9, 6'd32,
        6'd33, 6'd34, 6'd35, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd43
    };

    // Supported opcodes apart from opRtype and opRegimm
    localparam logic [opcodeCount*6-1:0] opcodeList = {
        6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7, 6'd8, 6'd9, 6'd10, 6'd11, 6'd12,
        6'd13, 6'd14, 6'd15, 6'd32, 6'd33, 6'd35, 6'd36, 6'd37, 6'd40, 6'd41, 6'd43
    };

    logic                   clk;
    logic                   reset;
    mipsControlPkg::wbReq_t wbReq;
    mipsControlPkg::wbRsp_t wbRsp;
    int                     errorCount;
    int                     assertFails;
    int                     seed;
    logic [31:0]            lastWord;

    mipsControl dut_i
    (
        .clk   (clk),
        .reset (reset),
        .wbReq (wbReq),
        .wbRsp (wbRsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Expected control word from the decode rules
    function automatic mipsControlPkg::ctrlWord_t expectCtrl(input logic [31:0] word);
        mipsControlPkg::ctrlWord_t e;
        logic [5:0]                op;
        logic [5:0]                fn;
        logic                      known;
        op    = word[31:26];
        fn    = word[5:0];
        e     = '0;
        known = 1'b1;
        if (op == 6'd0)
        begin
            e.regWrite = 1'b1;
            e.regDst   = mipsControlPkg::regDstRd;
            case (fn)
                6'd0, 6'd4:   e.aluOp = mipsControlPkg::aluSll;
                6'd2, 6'd6:   e.aluOp = mipsControlPkg::aluSrl;
                6'd3, 6'd7:   e.aluOp = mipsControlPkg::aluSra;
                6'd32, 6'd33: e.aluOp = mipsControlPkg::aluAdd;
                6'd34, 6'd35: e.aluOp = mipsControlPkg::aluSub;
                6'd36:        e.aluOp = mipsControlPkg::aluAnd;
                6'd37:        e.aluOp = mipsControlPkg::aluOr;
                6'd38:        e.aluOp = mipsControlPkg::aluXor;
                6'd39:        e.aluOp = mipsControlPkg::aluNor;
                6'd42:        e.aluOp = mipsControlPkg::aluSlt;
                6'd43:        e.aluOp = mipsControlPkg::aluSltu;
                6'd8, 6'd9:   e.jumpSrc = 1'b1;                  // jr and jalr
                default:      known = 1'b0;
            endcase
            if (fn < 6'd4)
                e.aluSrcA = mipsControlPkg::aluSrcShamt;         // Fixed shifts
            if (e.jumpSrc)
                e.npcType = mipsControlPkg::npcJump;
            if (fn == 6'd9)
                e.memToReg = mipsControlPkg::memToRegPc4;
            if (fn == 6'd8)
            begin
                e.regWrite = 1'b0;
                e.regDst   = mipsControlPkg::regDstRt;
            end
        end
        else
        begin
            case (op)
                6'd8, 6'd9: e.aluOp = mipsControlPkg::aluAdd;
                6'd10:      e.aluOp = mipsControlPkg::aluSlt;
                6'd11:      e.aluOp = mipsControlPkg::aluSltu;
                6'd12:      e.aluOp = mipsControlPkg::aluAndi;
                6'd13:      e.aluOp = mipsControlPkg::aluOri;
                6'd14:      e.aluOp = mipsControlPkg::aluXori;
                6'd15:      e.aluOp = mipsControlPkg::aluLui;
                6'd32:      e.memRBits = mipsControlPkg::memRByte;
                6'd33:      e.memRBits = mipsControlPkg::memRHalf;
                6'd35:      e.memRBits = mipsControlPkg::memRWord;
                6'd36:      e.memRBits = mipsControlPkg::memRByteU;
                6'd37:      e.memRBits = mipsControlPkg::memRHalfU;
                6'd40:      e.memWrBits = mipsControlPkg::memWrByte;
                6'd41:      e.memWrBits = mipsControlPkg::memWrHalf;
                6'd43:      e.memWrBits = mipsControlPkg::memWrWord;
                6'd4:       e.aluOp = mipsControlPkg::aluSub;
                6'd5:       e.aluOp = mipsControlPkg::aluBne;
                6'd6:       e.aluOp = mipsControlPkg::aluBlez;
                6'd7:       e.aluOp = mipsControlPkg::aluBgtz;
                6'd2, 6'd3: e.npcType = mipsControlPkg::npcJump;
                6'd1:
                begin
                    if (word[20:16] == 5'd0)
                        e.aluOp = mipsControlPkg::aluBltz;
                    else if (word[20:16] == 5'd1)
                        e.aluOp = mipsControlPkg::aluBgez;
                    else
                        known = 1'b0;
                end
                default:    known = 1'b0;
            endcase
            if (op[5:3] == 3'b001 || op[5:3] == 3'b100)
            begin
                e.regWrite = 1'b1;                               // Into rt
                e.aluSrcB  = mipsControlPkg::aluSrcImm;
            end
            if (op[5:3] == 3'b100)
            begin
                e.memRead  = 1'b1;
                e.memToReg = mipsControlPkg::memToRegMem;
                e.aluOp    = mipsControlPkg::aluAdd;
            end
            if (op[5:3] == 3'b101)
            begin
                e.memWrite = 1'b1;
                e.aluOp    = mipsControlPkg::aluAdd;
                e.aluSrcB  = mipsControlPkg::aluSrcImm;
            end
            if (op == 6'd1 || op[5:2] == 4'b0001)
            begin
                e.pcSrc   = 1'b1;
                e.npcType = mipsControlPkg::npcBranch;
            end
            if (op == 6'd3)
            begin
                e.regWrite = 1'b1;                               // Link into r31
                e.regDst   = mipsControlPkg::regDstRa;
                e.memToReg = mipsControlPkg::memToRegPc4;
            end
        end
        if (!known)
        begin
            e         = '0;
            e.illegal = 1'b1;
        end
        return e;
    endfunction

    // Classic cycle with the response sampled mid-cycle while ack is high
    task automatic busCycle(input logic we, input logic adr, input logic [31:0] data,
                            output logic [31:0] rsp);
        @(posedge clk);
        wbReq <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: data};
        do
            @(negedge clk);
        while (wbRsp.ack !== 1'b1);
        rsp = wbRsp.dat;
        @(posedge clk);
        wbReq <= '0;
    endtask

    task automatic wbWrite(input logic adr, input logic [31:0] data);
        logic [31:0] unused;
        busCycle(1'b1, adr, data, unused);
    endtask

    task automatic wbRead(input logic adr, output logic [31:0] data);
        busCycle(1'b0, adr, 32'd0, data);
    endtask

    task automatic compareWord(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected,
                     actual);
        end
    endtask

    task automatic compareReadbacks(input logic [31:0] word);
        logic [31:0] got;
        logic [31:0] expWord;
        expWord = {{(32 - $bits(mipsControlPkg::ctrlWord_t)){1'b0}}, expectCtrl(word)};
        wbRead(1'b1, got);
        compareWord("wbRsp.dat (control word)", expWord, got);
        wbRead(1'b0, got);
        compareWord("wbRsp.dat (instruction)", word, got);
    endtask

    task automatic checkInstr(input logic [31:0] word);
        wbWrite(1'b0, word);
        compareReadbacks(word);
    endtask

    initial
    begin
        reset      = 1'b1;
        wbReq      = '0;
        errorCount = 0;
        seed       = 81021;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compareWord("wbRsp.ack after reset", 32'd0, {31'd0, wbRsp.ack});
        compareReadbacks(32'd0);                        // Cleared register decodes as sll
        for (int i = 0; i < functCount; i++)
            checkInstr({6'd0, 5'd3, 5'd4, 5'd5, 5'd7, functList[i*6 +: 6]});
        for (int i = 0; i < opcodeCount; i++)
            checkInstr({opcodeList[i*6 +: 6], 5'd3, 5'd4, 16'h8010});
        checkInstr({mipsControlPkg::opRegimm, 5'd3, mipsControlPkg::rtBltz, 16'hfff0});
        checkInstr({mipsControlPkg::opRegimm, 5'd3, mipsControlPkg::rtBgez, 16'h0010});
        checkInstr({mipsControlPkg::opRegimm, 5'd3, 5'd2, 16'h0010});     // Not a branch
        checkInstr({6'd63, 26'h155_5555});                                  // Unknown opcode
        checkInstr({6'd0, 20'h1_2345, 6'd1});                               // Unknown funct
        lastWord = {mipsControlPkg::opLw, 5'd8, 5'd9, 16'h0040};
        checkInstr(lastWord);
        wbWrite(1'b1, 32'hffff_ffff);                                       // Must be ignored
        compareReadbacks(lastWord);
        for (int i = 0; i < randomCount; i++)
            wbWrite(1'b0, $random(seed));
        repeat (3) @(posedge clk);
        assertFails = dut_i.combine_i.combineChk_i.failCount
                      + dut_i.busPort_i.busChk_i.failCount;
        $display("Run complete: %0d mismatches, %0d assertion failures", errorCount,
                 assertFails);
        if (errorCount == 0 && assertFails == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (timeoutCycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", timeoutCycles);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== mipsControl.f ====
src/mipsControlPkg.sv
src/functDecoder.sv
src/opcodeDecoder.sv
src/controlCombine.sv
src/controlBusPort.sv
src/mipsControl.sv
bench/mipsControlAssert.sv
bench/mipsControlTb.sv
